// File: tb.f
nlc_pkg.sv
nlc_coeff_bank.sv
nlc_work_regs.sv
nlc_mac.sv
nlc_out_stage.sv
nlc_ctrl.sv
nlc_top.sv
tb_nlc.sv

// File: run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_nlc \
  -f tb.f --Mdir obj_dir -o sim_nlc
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_nlc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Errors found" "$LOG"; then
  exit 1
fi
exit 0

// File: tb_nlc.sv
module tb_nlc;

  import nlc_pkg::*;

  localparam int SMAX = (1 << (SAMPLE_W - 1)) - 1;
  localparam int SMIN = -(1 << (SAMPLE_W - 1));
  localparam int WAIT_LIMIT = 4 * RUN_CYCLES;

  logic                 clk;
  logic                 rst;
  logic                 start;
  sample_t [NUM_CH-1:0] x_adc;
  logic                 cfg_we;
  ch_t                  cfg_ch;
  chan_param_t          cfg_param;
  sample_t [NUM_CH-1:0] x_lin;
  logic                 done;

  chan_param_t          params [NUM_CH];
  int                   errors;
  int                   latency;

  nlc_top nlc_top_inst (
    .clk       (clk),
    .rst       (rst),
    .start     (start),
    .x_adc     (x_adc),
    .cfg_we    (cfg_we),
    .cfg_ch    (cfg_ch),
    .cfg_param (cfg_param),
    .x_lin     (x_lin),
    .done      (done)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic check_sample(string name, sample_t got, sample_t exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, got, exp);
    end
  endtask

  // Product in 64 bits, shifted, low DATA_W bits kept
  function automatic data_t fix_mul(data_t x, data_t y);
    longint full;
    full = longint'(x) * longint'(y);
    return data_t'(full >>> FRAC_BITS);
  endfunction

  function automatic sample_t model_out(chan_param_t prm, sample_t x);
    data_t norm;
    data_t acc;
    data_t scaled;
    norm = fix_mul((data_t'(x) <<< FRAC_BITS) + prm.neg_mean, prm.recip_stdev);
    acc  = prm.coeff[POLY_ORDER];
    for (int s = 1; s <= POLY_ORDER; s++) begin
      acc = fix_mul(acc, norm) + prm.coeff[POLY_ORDER - s];
    end
    scaled = acc >>> FRAC_BITS;
    if (scaled > SMAX) begin
      return sample_t'(SMAX);
    end else if (scaled < SMIN) begin
      return sample_t'(SMIN);
    end
    return sample_t'(scaled);
  endfunction

  function automatic data_t rand_span(int span);
    return data_t'(int'($urandom % (2 * span)) - span);
  endfunction

  // Identity map with an optional constant term
  function automatic chan_param_t identity_param(data_t c0);
    chan_param_t prm;
    prm             = '0;
    prm.recip_stdev = data_t'(1 << FRAC_BITS);
    prm.coeff[1]    = data_t'(1 << FRAC_BITS);
    prm.coeff[0]    = c0;
    return prm;
  endfunction

  task automatic load_params(int first, int last);
    for (int i = first; i <= last; i++) begin
      @(negedge clk);
      cfg_we    = 1'b1;
      cfg_ch    = ch_t'(i);
      cfg_param = params[i];
    end
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  // Pulses start and counts edges after the start edge until done
  // A nonzero busy_at adds a start mid-run
  task automatic run_once(int busy_at, output int cycles);
    sample_t [NUM_CH-1:0] held;
    logic                 seen;
    held = x_adc;
    seen = 1'b0;
    cycles = 0;
    @(negedge clk);
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_bit("done", done, 1'b0);
    while (!seen && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
      start = (cycles == busy_at);
      // Inputs change with the ignored start while results must not
      x_adc = (cycles == busy_at) ? ~held : held;
      seen = done;
    end
    x_adc = held;
    if (!seen) begin
      errors++;
      $display("Timeout: done did not rise within %0d cycles of start", WAIT_LIMIT);
    end
  endtask

  task automatic check_outputs();
    for (int i = 0; i < NUM_CH; i++) begin
      check_sample($sformatf("x_lin[%0d]", i), x_lin[i], model_out(params[i], x_adc[i]));
    end
  endtask

  task automatic randomize_channels();
    for (int i = 0; i < NUM_CH; i++) begin
      x_adc[i]              = sample_t'(rand_span(4096));
      params[i].neg_mean    = rand_span(1 << 20);
      params[i].recip_stdev = data_t'($urandom % 64);
      for (int k = 0; k <= POLY_ORDER; k++) begin
        params[i].coeff[k] = rand_span(256);
      end
    end
  endtask

  task automatic test_identity();
    for (int i = 0; i < NUM_CH; i++) begin
      params[i] = identity_param('0);
      x_adc[i]  = sample_t'($urandom);
    end
    load_params(0, NUM_CH - 1);
    run_once(0, latency);
    check_count("latency", latency, RUN_CYCLES);
    for (int i = 0; i < NUM_CH; i++) begin
      check_sample($sformatf("x_lin[%0d]", i), x_lin[i], x_adc[i]);
    end
  endtask

  task automatic test_random_poly();
    randomize_channels();
    load_params(0, NUM_CH - 1);
    run_once(0, latency);
    check_count("latency", latency, RUN_CYCLES);
    check_outputs();
  endtask

  // Large constant term pushes even channels up, odd channels down
  task automatic test_saturation();
    for (int i = 0; i < NUM_CH; i++) begin
      params[i] = identity_param((i % 2 == 0) ? data_t'(32'h4000_0000) : -data_t'(32'h4000_0000));
      x_adc[i]  = sample_t'(rand_span(4096));
    end
    load_params(0, NUM_CH - 1);
    run_once(0, latency);
    check_count("latency", latency, RUN_CYCLES);
    for (int i = 0; i < NUM_CH; i++) begin
      check_sample($sformatf("x_lin[%0d]", i), x_lin[i],
                   sample_t'((i % 2 == 0) ? SMAX : SMIN));
    end
  endtask

  task automatic test_busy_reprogram();
    sample_t [NUM_CH-1:0] prev;
    randomize_channels();
    load_params(0, NUM_CH - 1);
    run_once(RUN_CYCLES / 2, latency);
    check_count("latency", latency, RUN_CYCLES);
    check_outputs();
    prev      = x_lin;
    params[5] = identity_param(data_t'(1 << 12));
    load_params(5, 5);
    run_once(0, latency);
    check_count("latency", latency, RUN_CYCLES);
    check_outputs();
    for (int i = 0; i < NUM_CH; i++) begin
      if (i != 5) begin
        check_sample($sformatf("x_lin[%0d] unchanged", i), x_lin[i], prev[i]);
      end
    end
  endtask

  initial begin
    void'($urandom(84383));
    errors    = 0;
    rst       = 1'b1;
    start     = 1'b0;
    x_adc     = '0;
    cfg_we    = 1'b0;
    cfg_ch    = '0;
    cfg_param = '0;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    check_bit("done", done, 1'b0);
    test_identity();
    test_random_poly();
    test_saturation();
    test_busy_reprogram();
    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: nlc_top.sv
module nlc_top (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   start,
  input  nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_adc,
  input  logic                                   cfg_we,
  input  nlc_pkg::ch_t                           cfg_ch,
  input  nlc_pkg::chan_param_t                   cfg_param,
  output nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_lin,
  output logic                                   done
);

  import nlc_pkg::*;

  issue_t      issue;
  logic        capture;
  ch_t         rd_ch;
  chan_param_t rd_param;
  mac_op_t     op;
  logic        op_valid;
  mac_res_t    res;

  nlc_ctrl nlc_ctrl_inst (
    .clk     (clk),
    .rst     (rst),
    .start   (start),
    .issue   (issue),
    .capture (capture),
    .done    (done)
  );

  nlc_coeff_bank nlc_coeff_bank_inst (
    .clk       (clk),
    .rst       (rst),
    .cfg_we    (cfg_we),
    .cfg_ch    (cfg_ch),
    .cfg_param (cfg_param),
    .rd_ch     (rd_ch),
    .rd_param  (rd_param)
  );

  nlc_work_regs nlc_work_regs_inst (
    .clk      (clk),
    .rst      (rst),
    .capture  (capture),
    .x_adc    (x_adc),
    .issue    (issue),
    .rd_param (rd_param),
    .rd_ch    (rd_ch),
    .op       (op),
    .op_valid (op_valid),
    .res      (res)
  );

  nlc_mac nlc_mac_inst (
    .clk      (clk),
    .rst      (rst),
    .op       (op),
    .op_valid (op_valid),
    .res      (res)
  );

  nlc_out_stage nlc_out_stage_inst (
    .clk   (clk),
    .rst   (rst),
    .res   (res),
    .x_lin (x_lin)
  );

endmodule

// File: nlc_ctrl.sv
module nlc_ctrl (
  input  logic            clk,
  input  logic            rst,
  input  logic            start,
  output nlc_pkg::issue_t issue,
  output logic            capture,
  output logic            done
);

  import nlc_pkg::*;

  ctrl_state_t                          state;
  ch_t                                  ch_cnt;
  step_t                                step_cnt;
  logic                                 issue_en;
  logic [$clog2(MAC_LATENCY+1)-1:0]     drain_cnt;
  logic                                 accept;
  logic                                 last_issue;

  // Starts while busy are dropped
  assign accept     = start && (state == IDLE || state == DONE);
  assign capture    = accept;
  assign last_issue = issue_en && ch_cnt == ch_t'(NUM_CH - 1)
                      && step_cnt == step_t'(POLY_ORDER);
  assign issue      = '{valid: issue_en, ch: ch_cnt, step: step_cnt};

  always_ff @(posedge clk) begin
    if (rst) begin
      state     <= IDLE;
      ch_cnt    <= '0;
      step_cnt  <= '0;
      issue_en  <= 1'b0;
      drain_cnt <= '0;
      done      <= 1'b0;
    end else begin
      case (state)
        IDLE, DONE: begin
          if (accept) begin
            state    <= NORM;
            ch_cnt   <= '0;
            step_cnt <= '0;
            done     <= 1'b0;
          end
        end
        NORM, POLY: begin
          // Nothing issued in the capture cycle after start
          issue_en <= 1'b1;
          if (issue_en) begin
            ch_cnt <= ch_cnt + 1'b1;
            if (ch_cnt == ch_t'(NUM_CH - 1)) begin
              step_cnt <= step_cnt + 1'b1;
              state    <= POLY;
            end
            if (last_issue) begin
              issue_en  <= 1'b0;
              drain_cnt <= '0;
              state     <= DRAIN;
            end
          end
        end
        DRAIN: begin
          drain_cnt <= drain_cnt + 1'b1;
          // Pipeline plus output register
          if (drain_cnt == MAC_LATENCY) begin
            state <= DONE;
            done  <= 1'b1;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  a_idle_no_issue: assert property (@(posedge clk) disable iff (rst)
    (state == IDLE || state == DONE) |-> !issue.valid);

  // A channel's result must land before its next pass reads it
  a_interleave_depth: assert property (@(posedge clk) NUM_CH > MAC_LATENCY);

endmodule

// File: nlc_out_stage.sv
module nlc_out_stage (
  input  logic                                   clk,
  input  logic                                   rst,
  input  nlc_pkg::mac_res_t                      res,
  output nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_lin
);

  import nlc_pkg::*;

  data_t   scaled;
  sample_t sat;

  always_comb begin
    scaled = $signed(res.value) >>> FRAC_BITS;
    if (scaled > SAT_MAX) begin
      sat = sample_t'(SAT_MAX);
    end else if (scaled < SAT_MIN) begin
      sat = sample_t'(SAT_MIN);
    end else begin
      sat = sample_t'(scaled);
    end
  end

  // Only the last Horner pass is a finished result
  always_ff @(posedge clk) begin
    if (rst) begin
      x_lin <= '0;
    end else if (res.valid && res.tag.step == step_t'(POLY_ORDER)) begin
      x_lin[res.tag.ch] <= sat;
    end
  end

endmodule

// File: nlc_mac.sv
module nlc_mac (
  input  logic              clk,
  input  logic              rst,
  input  nlc_pkg::mac_op_t  op,
  input  logic              op_valid,
  output nlc_pkg::mac_res_t res
);

  import nlc_pkg::*;

  logic                       s1_valid;
  logic signed [2*DATA_W-1:0] s1_prod;
  data_t                      s1_c;
  mac_tag_t                   s1_tag;

  logic                       s2_valid;
  data_t                      s2_value;
  mac_tag_t                   s2_tag;

  data_t                      pre_sum;
  data_t                      mul_b;
  logic signed [2*DATA_W-1:0] prod;

  always_comb begin
    pre_sum = op.a + op.p;
    mul_b   = op.b;
    prod    = pre_sum * mul_b;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      s1_valid <= op_valid;
      s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    s1_prod  <= prod;
    s1_c     <= op.c;
    s1_tag   <= op.tag;
    // Arithmetic shift by FRAC_BITS, keep low DATA_W bits, wrap on add
    s2_value <= data_t'(s1_prod[FRAC_BITS +: DATA_W]) + s1_c;
    s2_tag   <= s1_tag;
  end

  assign res = '{valid: s2_valid, value: s2_value, tag: s2_tag};

endmodule

// File: nlc_work_regs.sv
module nlc_work_regs (
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   capture,
  input  nlc_pkg::sample_t [nlc_pkg::NUM_CH-1:0] x_adc,
  input  nlc_pkg::issue_t                        issue,
  input  nlc_pkg::chan_param_t                   rd_param,
  output nlc_pkg::ch_t                           rd_ch,
  output nlc_pkg::mac_op_t                       op,
  output logic                                   op_valid,
  input  nlc_pkg::mac_res_t                      res
);

  import nlc_pkg::*;

  sample_t [NUM_CH-1:0] samp_q;
  data_t                norm [NUM_CH];
  data_t                acc  [NUM_CH];

  always_ff @(posedge clk) begin
    if (capture) begin
      samp_q <= x_adc;
    end
  end

  assign rd_ch    = issue.ch;
  assign op_valid = issue.valid;

  always_comb begin
    data_t samp_ext;
    samp_ext = data_t'(samp_q[issue.ch]) <<< FRAC_BITS;
    op.tag   = '{ch: issue.ch, step: issue.step};
    if (issue.step == '0) begin
      // Normalize as (x + neg_mean) * recip_stdev
      op.a = samp_ext;
      op.p = rd_param.neg_mean;
      op.b = rd_param.recip_stdev;
      op.c = '0;
    end else begin
      // Horner step acc * norm + next lower coefficient
      op.a = acc[issue.ch];
      op.p = '0;
      op.b = norm[issue.ch];
      op.c = rd_param.coeff[POLY_ORDER - int'(issue.step)];
    end
  end

  // Scratch bank writeback by result tag
  always_ff @(posedge clk) begin
    if (rst) begin
      norm <= '{default: '0};
      acc  <= '{default: '0};
    end else begin
      if (issue.valid && issue.step == '0) begin
        acc[issue.ch] <= rd_param.coeff[POLY_ORDER];
      end
      if (res.valid) begin
        if (res.tag.step == '0) begin
          norm[res.tag.ch] <= res.value;
        end else begin
          acc[res.tag.ch] <= res.value;
        end
      end
    end
  end

  // Channel interleave keeps writeback away from the channel being read
  a_no_rw_clash: assert property (@(posedge clk) disable iff (rst)
    (res.valid && issue.valid) |-> (res.tag.ch != issue.ch));

endmodule

// File: nlc_coeff_bank.sv
module nlc_coeff_bank (
  input  logic                clk,
  input  logic                rst,
  input  logic                cfg_we,
  input  nlc_pkg::ch_t        cfg_ch,
  input  nlc_pkg::chan_param_t cfg_param,
  input  nlc_pkg::ch_t        rd_ch,
  output nlc_pkg::chan_param_t rd_param
);

  import nlc_pkg::*;

  chan_param_t bank [NUM_CH];

  // One channel's full parameter set per write
  always_ff @(posedge clk) begin
    if (rst) begin
      bank <= '{default: '0};
    end else if (cfg_we) begin
      bank[cfg_ch] <= cfg_param;
    end
  end

  // Combinational read for operand forming
  assign rd_param = bank[rd_ch];

endmodule

// File: nlc_pkg.sv
package nlc_pkg;

  localparam int NUM_CH      = 16;
  localparam int CH_W        = 4;
  localparam int SAMPLE_W    = 21;
  localparam int DATA_W      = 32;
  localparam int FRAC_BITS   = 8;
  localparam int POLY_ORDER  = 5;
  localparam int MAC_LATENCY = 2;

  // Capture + six passes over all channels + pipeline + output register
  localparam int RUN_CYCLES  = 1 + (POLY_ORDER + 1) * NUM_CH + MAC_LATENCY + 1;

  typedef logic signed [SAMPLE_W-1:0] sample_t;
  typedef logic signed [DATA_W-1:0]   data_t;
  typedef logic [CH_W-1:0]            ch_t;
  // 0 is normalization, 1..5 are Horner passes
  typedef logic [2:0]                 step_t;

  // Output clamp limits in data_t units
  localparam data_t SAT_MAX = (data_t'(1) <<< (SAMPLE_W - 1)) - data_t'(1);
  localparam data_t SAT_MIN = -(data_t'(1) <<< (SAMPLE_W - 1));

  typedef struct packed {
    data_t                  neg_mean;
    data_t                  recip_stdev;
    data_t [POLY_ORDER:0]   coeff;
  } chan_param_t;

  typedef struct packed {
    ch_t   ch;
    step_t step;
  } mac_tag_t;

  // ((a + p) * b >>> FRAC_BITS) + c
  typedef struct packed {
    data_t    a;
    data_t    p;
    data_t    b;
    data_t    c;
    mac_tag_t tag;
  } mac_op_t;

  typedef struct packed {
    logic     valid;
    data_t    value;
    mac_tag_t tag;
  } mac_res_t;

  typedef struct packed {
    logic  valid;
    ch_t   ch;
    step_t step;
  } issue_t;

  typedef enum logic [2:0] {
    IDLE,
    NORM,
    POLY,
    DRAIN,
    DONE
  } ctrl_state_t;

endpackage
